//--- hw/fetch_controller.sv
// Fetch controller FSM: line requests, issue handshake and flush recovery
`timescale 1ns/1ps

module fetch_controller (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic flush_i,
  input  logic pc_valid_i,
  // Incoming PC lies in the buffered line
  input  logic here_i,
  input  logic read_done_i,
  input  logic issue_ready_i,
  output logic fetch_ready_o,
  output logic read_req_o,
  output logic issue_valid_o,
  // Load the returning line into the buffer
  output logic use_fill_o
);

  fetch_pkg::fetch_state_t state_q;
  fetch_pkg::fetch_state_t state_d;
  // A read left in flight by a flush
  logic                    stale_q;
  logic                    stale_d;

  // ------------------------------------------------------------------
  // Next state and outputs
  // ------------------------------------------------------------------
  always_comb begin
    state_d       = state_q;
    fetch_ready_o = 1'b0;
    read_req_o    = 1'b0;
    issue_valid_o = 1'b0;
    use_fill_o    = 1'b0;
    case (state_q)
      fetch_pkg::S_IDLE: begin
        // Take a PC, then hit or miss
        fetch_ready_o = pc_valid_i;
        if (pc_valid_i) state_d = here_i ? fetch_pkg::S_ISSUE : fetch_pkg::S_REQ;
      end
      fetch_pkg::S_REQ: begin
        // Hold off while a stale read still drains
        read_req_o = ~stale_q;
        if (!stale_q) state_d = fetch_pkg::S_WAIT;
      end
      fetch_pkg::S_WAIT: begin
        if (read_done_i) begin
          use_fill_o = 1'b1;
          state_d    = fetch_pkg::S_ISSUE;
        end
      end
      fetch_pkg::S_ISSUE: begin
        issue_valid_o = 1'b1;
        // Accept the next PC in the same cycle as the issue
        if (issue_ready_i) begin
          fetch_ready_o = pc_valid_i;
          if (!pc_valid_i) state_d = fetch_pkg::S_IDLE;
          else if (here_i) state_d = fetch_pkg::S_ISSUE;
          else             state_d = fetch_pkg::S_REQ;
        end
      end
      default: state_d = fetch_pkg::S_IDLE;
    endcase

    // Flush kills everything this cycle
    if (flush_i) begin
      state_d       = fetch_pkg::S_IDLE;
      fetch_ready_o = 1'b0;
      read_req_o    = 1'b0;
      issue_valid_o = 1'b0;
      use_fill_o    = 1'b0;
    end
  end

  // Outstanding read at flush time becomes stale until its done
  always_comb begin
    stale_d = stale_q;
    if (read_done_i) stale_d = 1'b0;
    if (flush_i && (state_q == fetch_pkg::S_WAIT) && !read_done_i) stale_d = 1'b1;
  end

  // ------------------------------------------------------------------
  // State registers
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= fetch_pkg::S_IDLE;
      stale_q <= 1'b0;
    end else begin
      state_q <= state_d;
      stale_q <= stale_d;
    end
  end

endmodule

//--- hw/fetch_csr.sv
// Configuration registers for the fetch front end: boot PC and fetch enable
`timescale 1ns/1ps

module fetch_csr (
  input  logic             clk_i,
  input  logic             rst_n_i,

  // Single-cycle write port
  input  logic             cfg_we_i,
  input  logic             cfg_addr_i,
  input  fetch_pkg::addr_t cfg_wdata_i,

  // Toward the PC generator
  output fetch_pkg::cfg_t  cfg_o
);

  fetch_pkg::cfg_t  cfg_q;
  fetch_pkg::addr_t boot_wdata;

  // Boot PC is always word aligned
  assign boot_wdata = {cfg_wdata_i[fetch_pkg::XLEN-1:fetch_pkg::OFFSET],
                       {fetch_pkg::OFFSET{1'b0}}};

  // ------------------------------------------------------------------
  // Register file, two entries
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      // Nothing fetched until software enables
      cfg_q <= '0;
    end else if (cfg_we_i) begin
      if (cfg_addr_i == 1'b0) begin
        // Address 0 holds the boot PC
        cfg_q.boot_pc <= boot_wdata;
      end else begin
        // Address 1, only bit 0 is meaningful
        cfg_q.fetch_en <= cfg_wdata_i[0];
      end
    end
  end

  // Visible one cycle after the write
  assign cfg_o = cfg_q;

endmodule

//--- hw/fetch_pkg.sv
// Fetch front end shared definitions: widths, line geometry, types and payload structs
package fetch_pkg;

  // ------------------------------------------------------------------
  // Widths and geometry
  // ------------------------------------------------------------------
  localparam int XLEN        = 32;
  localparam int ILEN        = 32;
  localparam int LINE_WORDS  = 4;
  // Byte offset inside one instruction word
  localparam int OFFSET      = 2;
  // Word index inside one line
  localparam int LINE_OFFSET = 2;
  // Low address bits below the line number
  localparam int LINE_BITS   = OFFSET + LINE_OFFSET;
  // 64 lines of 16 bytes, so 1 KiB
  localparam int MEM_LINES   = 64;
  // Request to done, in cycles
  localparam int MEM_LAT     = 2;

  // ------------------------------------------------------------------
  // Plain vector types
  // ------------------------------------------------------------------
  typedef logic [XLEN-1:0]              addr_t;
  typedef logic [ILEN-1:0]              instr_t;
  typedef logic [$clog2(MEM_LINES)-1:0] line_idx_t;
  typedef logic [LINE_OFFSET-1:0]       word_idx_t;

  // Exception codes carried with a fetched slot
  typedef enum logic [1:0] {
    E_NONE,
    E_I_ACCESS_FAULT,
    E_UNKNOWN
  } except_code_t;

  // Fetch controller states
  typedef enum logic [1:0] {
    S_IDLE,
    S_REQ,
    S_WAIT,
    S_ISSUE
  } fetch_state_t;

  // Line memory answer, base address plus words plus fault flag
  typedef struct packed {
    addr_t                     base;
    instr_t [LINE_WORDS-1:0]   words;
    logic                      fault;
  } line_t;

  // Payload toward decode
  typedef struct packed {
    addr_t        pc;
    instr_t       instr;
    logic         except;
    except_code_t except_code;
  } fetch_pkt_t;

  // Boot configuration seen by the PC generator
  typedef struct packed {
    addr_t boot_pc;
    logic  fetch_en;
  } cfg_t;

endpackage

//--- hw/fetch_top.sv
// Fetch front end top: config block, PC generator, fetch unit and line memory
`timescale 1ns/1ps

module fetch_top (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  // Config write port
  input  logic                  cfg_we_i,
  input  logic                  cfg_addr_i,
  input  fetch_pkg::addr_t      cfg_wdata_i,

  // Memory load port
  input  logic                  mem_we_i,
  input  fetch_pkg::addr_t      mem_addr_i,
  input  fetch_pkg::instr_t     mem_wdata_i,

  // Redirect, doubles as flush
  input  logic                  redirect_valid_i,
  input  fetch_pkg::addr_t      redirect_pc_i,

  // Decode side
  input  logic                  issue_ready_i,
  output logic                  issue_valid_o,
  output fetch_pkg::fetch_pkt_t pkt_o
);

  fetch_pkg::cfg_t  cfg;
  fetch_pkg::addr_t pc;
  fetch_pkg::addr_t read_addr;
  fetch_pkg::line_t line;
  logic             pc_valid;
  logic             fetch_ready;
  logic             read_req;
  logic             read_done;
  logic             fault_issued;

  // Faulting slot accepted by decode
  assign fault_issued = issue_valid_o & issue_ready_i & pkt_o.except;

  fetch_csr u_fetch_csr (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_o       (cfg)
  );

  pc_gen u_pc_gen (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .cfg_i            (cfg),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .fault_issued_i   (fault_issued),
    .fetch_ready_i    (fetch_ready),
    .pc_valid_o       (pc_valid),
    .pc_o             (pc)
  );

  ifu u_ifu (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (redirect_valid_i),
    .pc_valid_i    (pc_valid),
    .pc_i          (pc),
    .fetch_ready_o (fetch_ready),
    .read_req_o    (read_req),
    .read_addr_o   (read_addr),
    .read_done_i   (read_done),
    .line_i        (line),
    .issue_ready_i (issue_ready_i),
    .issue_valid_o (issue_valid_o),
    .pkt_o         (pkt_o)
  );

  line_mem u_line_mem (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .mem_we_i    (mem_we_i),
    .mem_addr_i  (mem_addr_i),
    .mem_wdata_i (mem_wdata_i),
    .read_req_i  (read_req),
    .read_addr_i (read_addr),
    .read_done_o (read_done),
    .line_o      (line)
  );

endmodule

//--- hw/ifu.sv
// Instruction fetch unit: line buffer, presence check, fault mapping, issue path
`timescale 1ns/1ps

module ifu (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  flush_i,

  // PC handoff
  input  logic                  pc_valid_i,
  input  fetch_pkg::addr_t      pc_i,
  output logic                  fetch_ready_o,

  // Line memory
  output logic                  read_req_o,
  output fetch_pkg::addr_t      read_addr_o,
  input  logic                  read_done_i,
  input  fetch_pkg::line_t      line_i,

  // Toward decode
  input  logic                  issue_ready_i,
  output logic                  issue_valid_o,
  output fetch_pkg::fetch_pkt_t pkt_o
);

  fetch_pkg::line_t        buf_q;
  logic                    buf_valid_q;
  fetch_pkg::addr_t        cur_pc_q;
  fetch_pkg::except_code_t except_code;
  logic                    line_fault;
  logic                    here;
  logic                    pc_valid_ctl;
  logic                    fetch_ready;
  logic                    use_fill;

  // ------------------------------------------------------------------
  // Line buffer
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      buf_valid_q <= 1'b0;
    end else if (flush_i) begin
      buf_valid_q <= 1'b0;
    end else if (use_fill) begin
      buf_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (use_fill) buf_q <= line_i;
    // PC of the slot being worked on
    if (fetch_ready && pc_valid_i) cur_pc_q <= pc_i;
  end

  // Presence check on the line number
  assign here = buf_valid_q &&
    (pc_i[fetch_pkg::XLEN-1:fetch_pkg::LINE_BITS] ==
     buf_q.base[fetch_pkg::XLEN-1:fetch_pkg::LINE_BITS]);

  // Fault mapping
  assign line_fault = buf_valid_q & buf_q.fault;

  always_comb begin
    if (line_fault) except_code = fetch_pkg::E_I_ACCESS_FAULT;
    else            except_code = fetch_pkg::E_NONE;
  end

  // No new PC taken behind a faulting line
  assign pc_valid_ctl = pc_valid_i & ~line_fault;

  // Fill address is the line of the latched PC
  assign read_addr_o = {cur_pc_q[fetch_pkg::XLEN-1:fetch_pkg::LINE_BITS],
                        {fetch_pkg::LINE_BITS{1'b0}}};

  // ------------------------------------------------------------------
  // Controller and selector
  // ------------------------------------------------------------------
  fetch_controller u_fetch_controller (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .pc_valid_i    (pc_valid_ctl),
    .here_i        (here),
    .read_done_i   (read_done_i),
    .issue_ready_i (issue_ready_i),
    .fetch_ready_o (fetch_ready),
    .read_req_o    (read_req_o),
    .issue_valid_o (issue_valid_o),
    .use_fill_o    (use_fill)
  );

  instr_sel u_instr_sel (
    .line_i        (buf_q),
    .pc_i          (cur_pc_q),
    .except_code_i (except_code),
    .pkt_o         (pkt_o)
  );

  assign fetch_ready_o = fetch_ready;

endmodule

//--- hw/instr_sel.sv
// Instruction selector: picks the addressed word and builds the decode packet
`timescale 1ns/1ps

module instr_sel (
  input  fetch_pkg::line_t        line_i,
  input  fetch_pkg::addr_t        pc_i,
  input  fetch_pkg::except_code_t except_code_i,
  output fetch_pkg::fetch_pkt_t   pkt_o
);

  fetch_pkg::word_idx_t widx;
  fetch_pkg::instr_t    word;

  // Word index inside the line
  assign widx = pc_i[fetch_pkg::OFFSET +: fetch_pkg::LINE_OFFSET];

  // ------------------------------------------------------------------
  // Word mux
  // ------------------------------------------------------------------
  always_comb begin
    word = line_i.words[0];
    for (int w = 0; w < fetch_pkg::LINE_WORDS; w++) begin
      if (widx == fetch_pkg::word_idx_t'(w)) word = line_i.words[w];
    end
  end

  // Packet assembly
  always_comb begin
    pkt_o             = '0;
    pkt_o.pc          = pc_i;
    pkt_o.instr       = word;
    // Any code other than none marks an exception
    pkt_o.except      = (except_code_i != fetch_pkg::E_NONE);
    pkt_o.except_code = except_code_i;
  end

endmodule

//--- hw/line_mem.sv
// Instruction line memory: word-write load port, two-stage line read with range fault
`timescale 1ns/1ps

module line_mem (
  input  logic                clk_i,
  input  logic                rst_n_i,

  // Load port, one word per write
  input  logic                mem_we_i,
  input  fetch_pkg::addr_t    mem_addr_i,
  input  fetch_pkg::instr_t   mem_wdata_i,

  // Line read port
  input  logic                read_req_i,
  input  fetch_pkg::addr_t    read_addr_i,
  output logic                read_done_o,
  output fetch_pkg::line_t    line_o
);

  // Storage, one packed line per entry
  fetch_pkg::instr_t [fetch_pkg::LINE_WORDS-1:0] mem_q [fetch_pkg::MEM_LINES];

  fetch_pkg::line_idx_t wr_line;
  fetch_pkg::word_idx_t wr_word;
  logic                 wr_ok;
  logic                 rd_ok;

  // Stage 1 and stage 2 of the read
  logic                 s1_vld_q;
  fetch_pkg::addr_t     s1_base_q;
  logic                 s1_ok_q;
  logic                 done_q;
  fetch_pkg::line_t     line_q;

  // ------------------------------------------------------------------
  // Address decode
  // ------------------------------------------------------------------
  assign wr_line = mem_addr_i[fetch_pkg::LINE_BITS +: $bits(fetch_pkg::line_idx_t)];
  assign wr_word = mem_addr_i[fetch_pkg::OFFSET +: fetch_pkg::LINE_OFFSET];
  // In range when the line number is below the depth
  assign wr_ok   = (mem_addr_i >> fetch_pkg::LINE_BITS) < fetch_pkg::MEM_LINES;
  assign rd_ok   = (read_addr_i >> fetch_pkg::LINE_BITS) < fetch_pkg::MEM_LINES;

  // Word writes, out-of-range writes dropped
  always_ff @(posedge clk_i) begin
    if (mem_we_i && wr_ok) mem_q[wr_line][wr_word] <= mem_wdata_i;
  end

  // ------------------------------------------------------------------
  // Read pipeline
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s1_vld_q <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      s1_vld_q <= read_req_i;
      done_q   <= s1_vld_q;
    end
  end

  always_ff @(posedge clk_i) begin
    // Line base with the low bits cleared
    if (read_req_i) begin
      s1_base_q <= {read_addr_i[fetch_pkg::XLEN-1:fetch_pkg::LINE_BITS],
                    {fetch_pkg::LINE_BITS{1'b0}}};
      s1_ok_q   <= rd_ok;
    end
    // Faulting line returns zeros
    if (s1_vld_q) begin
      line_q.base  <= s1_base_q;
      line_q.words <= s1_ok_q ?
        mem_q[s1_base_q[fetch_pkg::LINE_BITS +: $bits(fetch_pkg::line_idx_t)]] : '0;
      line_q.fault <= ~s1_ok_q;
    end
  end

  assign read_done_o = done_q;
  assign line_o      = line_q;

endmodule

//--- hw/pc_gen.sv
// PC generator that boots from the configured PC, steps per handshake and takes redirects
`timescale 1ns/1ps

module pc_gen (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  fetch_pkg::cfg_t  cfg_i,
  input  logic             redirect_valid_i,
  input  fetch_pkg::addr_t redirect_pc_i,
  input  logic             fault_issued_i,
  input  logic             fetch_ready_i,
  output logic             pc_valid_o,
  output fetch_pkg::addr_t pc_o
);

  fetch_pkg::addr_t pc_q;
  // Fetch enable delayed by one cycle
  logic             en_q;
  logic             halt_q;
  logic             boot;

  // Rising edge of the fetch enable restarts from the boot PC
  assign boot = cfg_i.fetch_en & ~en_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q   <= '0;
      en_q   <= 1'b0;
      halt_q <= 1'b0;
    end else begin
      en_q <= cfg_i.fetch_en;
      // Redirect wins over boot and sequential step
      if (redirect_valid_i) begin
        pc_q   <= redirect_pc_i;
        halt_q <= 1'b0;
      end else if (boot) begin
        pc_q   <= cfg_i.boot_pc;
        halt_q <= 1'b0;
      end else begin
        if (pc_valid_o && fetch_ready_i) pc_q <= pc_q + 32'd4;
        // Stop after a faulting slot left for decode
        if (fault_issued_i) halt_q <= 1'b1;
      end
    end
  end

  assign pc_valid_o = en_q & ~halt_q;
  assign pc_o       = pc_q;

endmodule

//--- sim/fetch_tb.sv
// Testbench for the fetch front end with preload, reference model, stimulus and packet checker
`timescale 1ns/1ps

module fetch_tb;

  localparam int TIMEOUT   = 200;
  // Words held by the line memory making up 1 KiB
  localparam int MEM_WORDS = fetch_pkg::MEM_LINES * fetch_pkg::LINE_WORDS;

  logic                  clk_i;
  logic                  rst_n_i;
  logic                  cfg_we_i;
  logic                  cfg_addr_i;
  fetch_pkg::addr_t      cfg_wdata_i;
  logic                  mem_we_i;
  fetch_pkg::addr_t      mem_addr_i;
  fetch_pkg::instr_t     mem_wdata_i;
  logic                  redirect_valid_i;
  fetch_pkg::addr_t      redirect_pc_i;
  logic                  issue_ready_i;
  logic                  issue_valid_o;
  fetch_pkg::fetch_pkt_t pkt_o;

  // Copy of the preloaded words
  fetch_pkg::instr_t     mem_copy [MEM_WORDS];
  fetch_pkg::addr_t      exp_pc;
  fetch_pkg::fetch_pkt_t exp_pkt;
  fetch_pkg::fetch_pkt_t held_pkt;
  logic                  held;
  logic                  bp_mode;
  int                    errors;
  int                    pkt_count;
  int                    test_errs;
  int                    test_cnt;

  fetch_top u_fetch_top (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .cfg_we_i         (cfg_we_i),
    .cfg_addr_i       (cfg_addr_i),
    .cfg_wdata_i      (cfg_wdata_i),
    .mem_we_i         (mem_we_i),
    .mem_addr_i       (mem_addr_i),
    .mem_wdata_i      (mem_wdata_i),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .issue_ready_i    (issue_ready_i),
    .issue_valid_o    (issue_valid_o),
    .pkt_o            (pkt_o)
  );

  // 100 ns clock
  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Expected packet for one PC
  function automatic fetch_pkg::fetch_pkt_t expected_pkt(input fetch_pkg::addr_t pc);
    fetch_pkg::fetch_pkt_t p;
    p    = '0;
    p.pc = pc;
    if (pc >= MEM_WORDS * 4) begin
      // Past the memory depth the word is zero with an access fault
      p.except      = 1'b1;
      p.except_code = fetch_pkg::E_I_ACCESS_FAULT;
    end else begin
      p.instr       = mem_copy[pc >> 2];
      p.except_code = fetch_pkg::E_NONE;
    end
    return p;
  endfunction

  // ------------------------------------------------------------------
  // Checker sampled on the rising edge
  // ------------------------------------------------------------------
  always @(posedge clk_i) begin
    // Offered packet must not change under back-pressure
    if (issue_valid_o && held) begin
      assert (pkt_o == held_pkt) else begin
        errors++;
        $display("mismatch at %0t: held packet pc %h changed to pc %h instr %h",
                 $time, held_pkt.pc, pkt_o.pc, pkt_o.instr);
      end
    end
    if (issue_valid_o && issue_ready_i) begin
      exp_pkt = expected_pkt(exp_pc);
      assert (pkt_o == exp_pkt) else begin
        errors++;
        $display("mismatch at %0t: got pc %h instr %h exc %0d, expected pc %h instr %h exc %0d",
                 $time, pkt_o.pc, pkt_o.instr, pkt_o.except_code,
                 exp_pkt.pc, exp_pkt.instr, exp_pkt.except_code);
      end
      exp_pc = exp_pc + 32'd4;
      pkt_count++;
      held = 1'b0;
    end else if (issue_valid_o) begin
      held     = 1'b1;
      held_pkt = pkt_o;
    end else begin
      // Only a flush may take back an offered packet
      assert (!held || redirect_valid_i) else begin
        errors++;
        $display("error at %0t: offered packet withdrawn before it was accepted", $time);
      end
      held = 1'b0;
    end
    // Sequence restarts at the redirect target
    if (redirect_valid_i) exp_pc = redirect_pc_i;
  end

  task automatic finish_run();
    $display("checked %0d packets, %0d errors", pkt_count, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  task automatic begin_test();
    test_errs = errors;
    test_cnt  = pkt_count;
  endtask

  task automatic report_test(input string name);
    $display("test %s: %0d packets, %0d errors", name, pkt_count - test_cnt, errors - test_errs);
  endtask

  // Write ports called 1 ns after an edge
  task automatic cfg_write(input logic addr, input fetch_pkg::addr_t data);
    cfg_we_i    = 1'b1;
    cfg_addr_i  = addr;
    cfg_wdata_i = data;
    @(posedge clk_i);
    #1;
    cfg_we_i    = 1'b0;
  endtask

  task automatic mem_write(input fetch_pkg::addr_t addr, input fetch_pkg::instr_t data);
    mem_we_i    = 1'b1;
    mem_addr_i  = addr;
    mem_wdata_i = data;
    @(posedge clk_i);
    #1;
    mem_we_i    = 1'b0;
  endtask

  task automatic redirect_to(input fetch_pkg::addr_t pc);
    redirect_valid_i = 1'b1;
    redirect_pc_i    = pc;
    @(posedge clk_i);
    #1;
    redirect_valid_i = 1'b0;
  endtask

  // Wait for n accepted packets with the timeout restarted on each packet
  task automatic wait_packets(input int n);
    int target;
    int idle;
    int last;
    target = pkt_count + n;
    idle   = 0;
    last   = pkt_count;
    while (pkt_count < target && idle < TIMEOUT) begin
      @(posedge clk_i);
      #1;
      if (bp_mode) begin
        issue_ready_i = ($urandom & 1) != 0;
      end else begin
        issue_ready_i = 1'b1;
      end
      if (pkt_count != last) begin
        idle = 0;
        last = pkt_count;
      end else begin
        idle++;
      end
    end
    if (pkt_count < target) begin
      errors++;
      $display("error at %0t: no packet for %0d cycles, %0d still missing",
               $time, TIMEOUT, target - pkt_count);
      finish_run();
    end
  endtask

  // Returns in the first cycle of a line fill
  task automatic wait_fill_start();
    logic seen;
    int   n;
    seen = 1'b0;
    n    = 0;
    while (!seen && n < TIMEOUT) begin
      @(posedge clk_i);
      seen = u_fetch_top.read_req;
      #1;
      n++;
    end
    if (!seen) begin
      errors++;
      $display("error at %0t: no line read request seen", $time);
      finish_run();
    end
  endtask

  // Issue side idle for 8 cycles in a row
  task automatic wait_quiet();
    int quiet;
    int n;
    quiet = 0;
    n     = 0;
    while (quiet < 8 && n < TIMEOUT) begin
      @(posedge clk_i);
      #1;
      n++;
      if (issue_valid_o) quiet = 0;
      else               quiet++;
    end
    if (quiet < 8) begin
      errors++;
      $display("error at %0t: fetch did not stop after disable", $time);
      finish_run();
    end
  endtask

  // ------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------
  initial begin
    fetch_pkg::addr_t target;
    int               i;
    int               last;
    void'($urandom(32'h23fd_8b50));
    rst_n_i          = 1'b0;
    cfg_we_i         = 1'b0;
    cfg_addr_i       = 1'b0;
    cfg_wdata_i      = '0;
    mem_we_i         = 1'b0;
    mem_addr_i       = '0;
    mem_wdata_i      = '0;
    redirect_valid_i = 1'b0;
    redirect_pc_i    = '0;
    issue_ready_i    = 1'b1;
    bp_mode          = 1'b0;
    held             = 1'b0;
    errors           = 0;
    pkt_count        = 0;
    exp_pc           = '0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    // Random program over the whole memory
    for (i = 0; i < MEM_WORDS; i++) begin
      mem_copy[i] = $urandom;
      mem_write(fetch_pkg::addr_t'(i * 4), mem_copy[i]);
    end

    // Sequential fetch from boot PC 0
    begin_test();
    exp_pc = '0;
    cfg_write(1'b0, 32'd0);
    cfg_write(1'b1, 32'd1);
    wait_packets(40);
    report_test("sequential");

    // Random ready toward decode
    begin_test();
    bp_mode = 1'b1;
    wait_packets(40);
    bp_mode       = 1'b0;
    issue_ready_i = 1'b1;
    report_test("backpressure");

    // Targets kept clear of the fault region
    begin_test();
    for (i = 0; i < 3; i++) begin
      target = fetch_pkg::addr_t'(($urandom % 192) * 4);
      redirect_to(target);
      wait_packets(6);
    end
    // Flush while a line read is outstanding
    wait_fill_start();
    target = fetch_pkg::addr_t'(($urandom % 192) * 4);
    redirect_to(target);
    wait_packets(6);
    report_test("redirect");

    // Last line then one faulting slot and a halt
    begin_test();
    redirect_to(32'd1016);
    wait_packets(3);
    last = pkt_count;
    repeat (50) @(posedge clk_i);
    #1;
    assert (pkt_count == last) else begin
      errors++;
      $display("error at %0t: packet issued after the access fault", $time);
    end
    redirect_to(32'h100);
    wait_packets(4);
    report_test("access fault");

    // Disable, set a new boot PC and enable again
    begin_test();
    cfg_write(1'b1, 32'd0);
    wait_quiet();
    target = fetch_pkg::addr_t'(($urandom % 192) * 4);
    exp_pc = target;
    cfg_write(1'b0, target);
    cfg_write(1'b1, 32'd1);
    wait_packets(8);
    report_test("boot reconfig");

    finish_run();
  end

endmodule

//--- verilog.f
hw/fetch_pkg.sv
hw/fetch_csr.sv
hw/pc_gen.sv
hw/line_mem.sv
hw/fetch_controller.sv
hw/instr_sel.sv
hw/ifu.sv
hw/fetch_top.sv
sim/fetch_tb.sv
